// ==== logic/hsk_io_defines.svh ====
`ifndef HSK_IO_DEFINES_SVH
`define HSK_IO_DEFINES_SVH

// processor port map
`define HSK_UART_PORT       8'h08
`define HSK_CTLSTAT_PORT    8'h0B
`define HSK_SCL_PORT        8'h0D
`define HSK_SDA_PORT        8'h0E
`define HSK_GC_PORT         8'h11

// decode masks, bits 6:5 are don't-care everywhere
`define HSK_MASK_UARTTX     8'b1001_1110
`define HSK_MASK_UARTRX     8'b1001_1101
`define HSK_MASK_SCL        8'b1001_1101
`define HSK_MASK_SDA        8'b1001_1110
`define HSK_MASK_GC         8'b1001_0001

// bit positions inside the port bytes
`define HSK_SDA_BIT         0
`define HSK_SCL_BIT         1
`define HSK_CS_BANK_BIT     1
`define HSK_CS_RESET_BIT    7
`define HSK_GC_HSKBUF_BIT   0
`define HSK_GC_CRATE_BIT    6
`define HSK_GC_ENABLE_BIT   7
`define HSK_PORT_BUF_BIT    7

// widths
`define HSK_BRAM_AW         11
`define HSK_WB_AW           12
`define HSK_WB_DW           32

// fixed top bits of the id byte
`define HSK_ID_PREFIX       3'b010

`endif

// ==== logic/hsk_io_pkg.sv ====
package hsk_io_pkg;

    // one-cycle select pulses out of the port decoder
    typedef struct packed {
        logic gc_wr;
        logic scl_wr;
        logic sda_wr;
        logic ctlstat_wr;
        logic uart_wr;
        logic uart_rd;
        logic bram_wr;
    } port_sel_t;

    // general control byte as the processor reads it back
    // bit 7 enable line, bit 6 cratebridge, bit 0 hsk buffer select
    typedef struct packed {
        logic       enable_in;
        logic       cratebridge_actual;
        logic [4:0] rsvd;
        logic       hsk_buf;
    } gen_ctl_t;

    // cobs receive status, captured on the last completed read
    typedef struct packed {
        logic [5:0] zero;
        logic       last;
        logic       error;
    } cobs_status_t;

endpackage

// ==== logic/pb_port_if.sv ====
// decoded processor port bus, decoder side to register blocks
interface pb_port_if;
    import hsk_io_pkg::*;

    // raw port number as the core drives it
    logic [7:0] port_id;
    // port number after the constant-port remap
    logic [7:0] kport_id;
    // write data
    logic [7:0] out_port;
    // register bank currently active in the core
    logic       bank;
    // strobes, all combinational with the core strobe
    port_sel_t  sel;

    modport decoder (
        output port_id, kport_id, out_port, bank, sel
    );

    modport target (
        input port_id, kport_id, out_port, bank, sel
    );

endinterface

// ==== logic/port_decode.sv ====
`include "hsk_io_defines.svh"

module port_decode (
    input  logic [7:0] port_id_i,
    input  logic [7:0] out_port_i,
    input  logic       write_strobe_i,
    input  logic       k_write_strobe_i,
    input  logic       read_strobe_i,
    input  logic       bank_i,
    pb_port_if.decoder bus
);
    import hsk_io_pkg::*;

    logic [7:0] kport_id;
    logic       any_wr;
    port_sel_t  sel;

    // masked compare with the target masked too so don't-care bits never matter
    function automatic logic port_match(input logic [7:0] port,
                                        input logic [7:0] mask,
                                        input logic [7:0] target);
        return (port & mask) == (target & mask);
    endfunction

    // k-ports 0-7 move up to 0x80-0x87 and 8-F keep their numbers
    // so the low buffer double-map stays intact
    assign kport_id = k_write_strobe_i ? {~port_id_i[3], 3'b000, port_id_i[3:0]} : port_id_i;
    assign any_wr   = write_strobe_i | k_write_strobe_i;

    ////////////////////////////////////////
    // select pulses
    ////////////////////////////////////////
    always_comb begin
        // general control only takes a normal output
        sel.gc_wr      = write_strobe_i & port_match(port_id_i, `HSK_MASK_GC, `HSK_GC_PORT);
        sel.scl_wr     = any_wr & port_match(kport_id, `HSK_MASK_SCL, `HSK_SCL_PORT);
        sel.sda_wr     = any_wr & port_match(kport_id, `HSK_MASK_SDA, `HSK_SDA_PORT);
        // ctlstat and uart share a mask and differ in bit 1
        sel.ctlstat_wr = any_wr & port_match(kport_id, `HSK_MASK_UARTTX, `HSK_CTLSTAT_PORT);
        sel.uart_wr    = any_wr & port_match(kport_id, `HSK_MASK_UARTTX, `HSK_UART_PORT);
        sel.uart_rd    = read_strobe_i & port_match(port_id_i, `HSK_MASK_UARTRX, `HSK_UART_PORT);
        // whole upper half of the port space is the buffer
        sel.bram_wr    = any_wr & kport_id[`HSK_PORT_BUF_BIT];
    end

    assign bus.port_id  = port_id_i;
    assign bus.kport_id = kport_id;
    assign bus.out_port = out_port_i;
    assign bus.bank     = bank_i;
    assign bus.sel      = sel;

    // a control write must never also push a byte into the transmit path
    always_comb begin
        assert (!(sel.ctlstat_wr && sel.uart_wr))
            else $error("ctlstat and uart write decoded together");
    end

endmodule

// ==== logic/hsk_control.sv ====
`include "hsk_io_defines.svh"

module hsk_control (
    input  logic                  wb_clk_i,
    input  logic                  sys_rst_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [3:0]            wb_sel_i,
    input  logic [`HSK_WB_DW-1:0] wb_dat_i,
    output logic [`HSK_WB_DW-1:0] wb_dat_o,
    output logic                  wb_ack_o,
    output logic                  processor_reset_o,
    pb_port_if.target             bus,
    input  logic                  cratebridge_en_i,
    output logic                  cratebridge_en_o,
    input  logic                  hsk_enable_i,
    output logic                  hsk_enable_o,
    output logic                  hsk_enable_t_o,
    output logic                  sda_t_o,
    output logic                  scl_t_o,
    output logic                  hsk_buf_o,
    output hsk_io_pkg::gen_ctl_t  gen_ctl_o
);

    ////////////////////////////////////////
    // system reset edge
    ////////////////////////////////////////
    // two stage history of sys_rst_i, 01 marks the rise
    logic [1:0] sys_rst_q = 2'b00;
    logic       sys_reset_flag;
    // holds the core in reset
    logic       processor_reset = 1'b0;
    logic       ack_q = 1'b0;
    logic       wb_write;
    // requested and observed cratebridge state
    logic       cratebridge_en_q = 1'b0;
    logic       cratebridge_act_q = 1'b0;
    logic       hsk_buf_q = 1'b0;
    // open-drain line registers, high means released
    logic       scl_t_q = 1'b1;
    logic       sda_t_q = 1'b1;

    assign sys_reset_flag = (sys_rst_q == 2'b01);
    // write lands on the acked beat only
    assign wb_write = wb_cyc_i & wb_stb_i & wb_we_i & ack_q & wb_sel_i[0];

    always_ff @(posedge wb_clk_i) begin
        sys_rst_q <= {sys_rst_q[0], sys_rst_i};
        ack_q     <= wb_cyc_i & wb_stb_i;
        // in at the rise, out again the cycle after
        // relies on sys_rst_i being wider than one clock
        if (sys_rst_q[0]) begin
            processor_reset <= sys_reset_flag;
        end else if (wb_write) begin
            processor_reset <= wb_dat_i[0];
        end
        // system reset drops cratebridge, core reset leaves it alone
        if (sys_reset_flag) begin
            cratebridge_en_q <= 1'b0;
        end else if (bus.sel.gc_wr) begin
            cratebridge_en_q <= bus.out_port[`HSK_GC_CRATE_BIT];
            hsk_buf_q        <= bus.out_port[`HSK_GC_HSKBUF_BIT];
        end
        cratebridge_act_q <= cratebridge_en_i;
    end

    ////////////////////////////////////////
    // i2c lines
    ////////////////////////////////////////
    always_ff @(posedge wb_clk_i) begin
        // release both lines while the core is held
        if (processor_reset) begin
            scl_t_q <= 1'b1;
            sda_t_q <= 1'b1;
        end else begin
            if (bus.sel.scl_wr) begin
                scl_t_q <= bus.out_port[`HSK_SCL_BIT];
            end
            if (bus.sel.sda_wr) begin
                sda_t_q <= bus.out_port[`HSK_SDA_BIT];
            end
        end
    end

    // enable line is only driven from here during a gc write
    assign hsk_enable_t_o    = ~bus.sel.gc_wr;
    assign hsk_enable_o      = bus.out_port[`HSK_GC_ENABLE_BIT];
    assign cratebridge_en_o  = cratebridge_en_q;
    assign hsk_buf_o         = hsk_buf_q;
    assign gen_ctl_o         = '{enable_in: hsk_enable_i, cratebridge_actual: cratebridge_act_q,
                                 rsvd: '0, hsk_buf: hsk_buf_q};
    assign scl_t_o           = scl_t_q;
    assign sda_t_o           = sda_t_q;
    assign processor_reset_o = processor_reset;
    assign wb_ack_o          = ack_q & wb_cyc_i;
    assign wb_dat_o          = {{(`HSK_WB_DW-2){1'b0}}, cratebridge_act_q, processor_reset};

    // sys_rst_i rise gives exactly one cycle of core reset
    assert property (@(posedge wb_clk_i) sys_reset_flag |=> processor_reset ##1 !processor_reset)
        else $error("processor reset from sys_rst_i not a single pulse");

endmodule

// ==== logic/buffer_ctl.sv ====
`include "hsk_io_defines.svh"

module buffer_ctl (
    input  logic                    wb_clk_i,
    pb_port_if.target               bus,
    input  logic                    hsk_buf_i,
    output logic                    hsk_reset_o,
    output logic [`HSK_BRAM_AW-1:0] bram_addr_o,
    output logic                    bram_we_o,
    output logic                    bram_en_o
);

    // held high until the core releases it
    logic hsk_reset = 1'b1;
    // packet buffer half for each core bank
    logic bank_a = 1'b0;
    logic bank_b = 1'b0;
    logic packet_bit6;
    logic hsk_bit6;
    logic bram_bit6;

    ////////////////////////////////////////
    // control/status register
    ////////////////////////////////////////
    always_ff @(posedge wb_clk_i) begin
        if (bus.sel.ctlstat_wr) begin
            hsk_reset <= bus.out_port[`HSK_CS_RESET_BIT];
            // only the active bank's half pointer moves
            if (bus.bank) begin
                bank_b <= bus.out_port[`HSK_CS_BANK_BIT];
            end else begin
                bank_a <= bus.out_port[`HSK_CS_BANK_BIT];
            end
        end
    end

    // packet ports pick the half by bank
    // hsk ports write one half and read the other
    assign packet_bit6 = bus.bank ? bank_b : bank_a;
    assign hsk_bit6    = bus.sel.bram_wr ? hsk_buf_i : ~hsk_buf_i;
    assign bram_bit6   = bus.kport_id[6] ? hsk_bit6 : packet_bit6;

    // packet region 0x700-0x77F and hsk region 0x780-0x7FF
    assign bram_addr_o = {3'b111, bus.kport_id[6], bram_bit6, bus.kport_id[5:0]};
    assign bram_we_o   = bus.sel.bram_wr;
    assign bram_en_o   = bus.kport_id[`HSK_PORT_BUF_BIT];
    assign hsk_reset_o = hsk_reset;

endmodule

// ==== logic/port_readback.sv ====
`include "hsk_io_defines.svh"

module port_readback (
    input  logic                 wb_clk_i,
    pb_port_if.target            bus,
    input  logic [1:0]           conf_i,
    input  hsk_io_pkg::gen_ctl_t gen_ctl_i,
    input  logic [7:0]           bram_data_i,
    input  logic                 sda_i,
    input  logic                 scl_i,
    input  logic [7:0]           cobs_rx_tdata_i,
    input  logic                 cobs_rx_tvalid_i,
    input  logic                 cobs_rx_tlast_i,
    input  logic                 cobs_rx_tuser_i,
    output logic                 cobs_rx_tready_o,
    output logic [7:0]           cobs_tx_tdata_o,
    output logic                 cobs_tx_tvalid_o,
    output logic                 cobs_tx_tlast_o,
    output logic                 interrupt_o,
    output logic [7:0]           in_port_o
);
    import hsk_io_pkg::*;

    cobs_status_t cobs_status = '0;
    logic [7:0]   our_id;
    logic [7:0]   i2c_in;

    // 0x40 + conf*8
    assign our_id = {`HSK_ID_PREFIX, conf_i, 3'b000};
    assign i2c_in = {6'b000000, scl_i, sda_i};

    // status reflects the byte the core just took
    always_ff @(posedge wb_clk_i) begin
        if (bus.sel.uart_rd && cobs_rx_tvalid_i) begin
            cobs_status.last  <= cobs_rx_tlast_i;
            cobs_status.error <= cobs_rx_tuser_i;
        end
    end

    ////////////////////////////////////////
    // read mux
    ////////////////////////////////////////
    always_comb begin
        if (bus.port_id[`HSK_PORT_BUF_BIT]) begin
            in_port_o = bram_data_i;
        end else if (bus.port_id[4]) begin
            // 0x10 id, 0x11 general control
            in_port_o = bus.port_id[0] ? gen_ctl_i : our_id;
        end else begin
            case (bus.port_id[3:1])
                // 0x08-0x0B, odd ports are status
                3'b100, 3'b101: in_port_o = bus.port_id[0] ? cobs_status : cobs_rx_tdata_i;
                3'b110:         in_port_o = i2c_in;
                3'b111:         in_port_o = 8'h00;
                // low eight alias the buffer
                default:        in_port_o = bram_data_i;
            endcase
        end
    end

    // no back-pressure either way
    assign cobs_rx_tready_o = bus.sel.uart_rd;
    assign cobs_tx_tvalid_o = bus.sel.uart_wr;
    assign cobs_tx_tdata_o  = bus.out_port;
    assign cobs_tx_tlast_o  = bus.port_id[0];
    assign interrupt_o      = cobs_rx_tvalid_i;

endmodule

// ==== logic/hsk_io_top.sv ====
`include "hsk_io_defines.svh"

module hsk_io_top (
    input  logic                    wb_clk_i,
    input  logic                    sys_rst_i,
    // wishbone slave, single register
    input  logic                    wb_cyc_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  logic [3:0]              wb_sel_i,
    input  logic [`HSK_WB_DW-1:0]   wb_dat_i,
    output logic [`HSK_WB_DW-1:0]   wb_dat_o,
    output logic                    wb_ack_o,
    output logic                    processor_reset_o,
    // processor port bus
    input  logic [7:0]              port_id_i,
    input  logic [7:0]              out_port_i,
    input  logic                    write_strobe_i,
    input  logic                    k_write_strobe_i,
    input  logic                    read_strobe_i,
    input  logic                    bank_i,
    output logic [7:0]              in_port_o,
    output logic                    interrupt_o,
    // crate side
    input  logic                    cratebridge_en_i,
    output logic                    cratebridge_en_o,
    input  logic                    hsk_enable_i,
    output logic                    hsk_enable_o,
    output logic                    hsk_enable_t_o,
    input  logic [1:0]              conf_i,
    // i2c pins
    input  logic                    sda_i,
    input  logic                    scl_i,
    output logic                    sda_t_o,
    output logic                    scl_t_o,
    // buffer ram
    input  logic [7:0]              bram_data_i,
    output logic                    hsk_reset_o,
    output logic [`HSK_BRAM_AW-1:0] bram_addr_o,
    output logic                    bram_we_o,
    output logic                    bram_en_o,
    // cobs byte streams
    input  logic [7:0]              cobs_rx_tdata_i,
    input  logic                    cobs_rx_tvalid_i,
    input  logic                    cobs_rx_tlast_i,
    input  logic                    cobs_rx_tuser_i,
    output logic                    cobs_rx_tready_o,
    output logic [7:0]              cobs_tx_tdata_o,
    output logic                    cobs_tx_tvalid_o,
    output logic                    cobs_tx_tlast_o
);
    import hsk_io_pkg::*;

    logic     hsk_buf;
    gen_ctl_t gen_ctl;

    pb_port_if u_bus ();

    port_decode u_decode (
        .port_id_i(port_id_i), .out_port_i(out_port_i), .write_strobe_i(write_strobe_i),
        .k_write_strobe_i(k_write_strobe_i), .read_strobe_i(read_strobe_i),
        .bank_i(bank_i), .bus(u_bus.decoder)
    );

    hsk_control u_control (
        .wb_clk_i(wb_clk_i), .sys_rst_i(sys_rst_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
        .wb_we_i(wb_we_i), .wb_sel_i(wb_sel_i), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o),
        .wb_ack_o(wb_ack_o), .processor_reset_o(processor_reset_o), .bus(u_bus.target),
        .cratebridge_en_i(cratebridge_en_i), .cratebridge_en_o(cratebridge_en_o),
        .hsk_enable_i(hsk_enable_i), .hsk_enable_o(hsk_enable_o),
        .hsk_enable_t_o(hsk_enable_t_o), .sda_t_o(sda_t_o), .scl_t_o(scl_t_o),
        .hsk_buf_o(hsk_buf), .gen_ctl_o(gen_ctl)
    );

    buffer_ctl u_buffer (
        .wb_clk_i(wb_clk_i), .bus(u_bus.target), .hsk_buf_i(hsk_buf),
        .hsk_reset_o(hsk_reset_o), .bram_addr_o(bram_addr_o), .bram_we_o(bram_we_o),
        .bram_en_o(bram_en_o)
    );

    port_readback u_readback (
        .wb_clk_i(wb_clk_i), .bus(u_bus.target), .conf_i(conf_i), .gen_ctl_i(gen_ctl),
        .bram_data_i(bram_data_i), .sda_i(sda_i), .scl_i(scl_i),
        .cobs_rx_tdata_i(cobs_rx_tdata_i), .cobs_rx_tvalid_i(cobs_rx_tvalid_i),
        .cobs_rx_tlast_i(cobs_rx_tlast_i), .cobs_rx_tuser_i(cobs_rx_tuser_i),
        .cobs_rx_tready_o(cobs_rx_tready_o), .cobs_tx_tdata_o(cobs_tx_tdata_o),
        .cobs_tx_tvalid_o(cobs_tx_tvalid_o), .cobs_tx_tlast_o(cobs_tx_tlast_o),
        .interrupt_o(interrupt_o), .in_port_o(in_port_o)
    );

endmodule

// ==== verification/hsk_io_checker.sv ====
`include "hsk_io_defines.svh"

module hsk_io_checker (
    input  logic                    clk_i,
    input  logic                    done_i,
    input  logic                    chk_valid_i,
    input  int                      chk_test_i,
    input  logic [7:0]              chk_sig_i,
    input  logic [31:0]             chk_exp_i,
    // receive valid as driven into the dut
    input  logic                    rx_tvalid_i,
    // dut outputs under watch
    input  logic                    processor_reset_i,
    input  logic                    cratebridge_en_i,
    input  logic                    wb_ack_i,
    input  logic [`HSK_WB_DW-1:0]   wb_dat_i,
    input  logic [7:0]              in_port_i,
    input  logic                    interrupt_i,
    input  logic                    scl_t_i,
    input  logic                    sda_t_i,
    input  logic                    hsk_enable_t_i,
    input  logic                    hsk_enable_i,
    input  logic                    hsk_reset_i,
    input  logic [`HSK_BRAM_AW-1:0] bram_addr_i,
    input  logic                    bram_we_i,
    input  logic                    bram_en_i,
    input  logic                    cobs_rx_tready_i,
    input  logic                    cobs_tx_tvalid_i,
    input  logic                    cobs_tx_tlast_i,
    input  logic [7:0]              cobs_tx_tdata_i,
    output int                      error_count_o,
    output logic                    summary_done_o
);

    int    cur_test = 0;
    bit    have_test = 0;
    int    test_checks = 0;
    int    test_errors = 0;
    int    total_checks = 0;
    int    total_tests = 0;
    int    failed_tests = 0;
    int    error_count = 0;
    logic  summary_done = 1'b0;

    assign error_count_o  = error_count;
    assign summary_done_o = summary_done;

    // pick the output a vector names
    function automatic logic [31:0] observed(input logic [7:0] sig);
        case (sig)
            8'h00:   return {31'd0, processor_reset_i};
            8'h01:   return {31'd0, cratebridge_en_i};
            8'h02:   return {31'd0, wb_ack_i};
            8'h03:   return wb_dat_i;
            8'h04:   return {24'd0, in_port_i};
            8'h05:   return {31'd0, scl_t_i};
            8'h06:   return {31'd0, sda_t_i};
            8'h07:   return {31'd0, hsk_enable_t_i};
            8'h08:   return {31'd0, hsk_enable_i};
            8'h09:   return {31'd0, hsk_reset_i};
            8'h0a:   return {21'd0, bram_addr_i};
            8'h0b:   return {31'd0, bram_we_i};
            8'h0c:   return {31'd0, bram_en_i};
            8'h0d:   return {31'd0, cobs_rx_tready_i};
            8'h0e:   return {31'd0, cobs_tx_tvalid_i};
            8'h0f:   return {31'd0, cobs_tx_tlast_i};
            8'h10:   return {24'd0, cobs_tx_tdata_i};
            default: return 32'hxxxx_xxxx;
        endcase
    endfunction

    // one summary line when a test is over
    task automatic close_test();
        total_tests++;
        if (test_errors != 0) begin
            failed_tests++;
        end
        $display("test %0d %s: %0d checks, %0d errors", cur_test,
                 (test_errors == 0) ? "ok" : "failed", test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    ////////////////////////////////////////
    // compare on the falling edge
    ////////////////////////////////////////
    // inputs settle half a cycle after the tb drives them
    always @(negedge clk_i) begin
        logic [31:0] got;
        if (done_i && !summary_done) begin
            if (have_test) begin
                close_test();
            end
            $display("%0d tests, %0d failed, %0d checks, %0d errors",
                     total_tests, failed_tests, total_checks, error_count);
            summary_done = 1'b1;
        end else if (chk_valid_i) begin
            if (have_test && chk_test_i != cur_test) begin
                close_test();
            end
            cur_test  = chk_test_i;
            have_test = 1;
            // a waiting receive byte always raises the interrupt
            test_checks++;
            total_checks++;
            if (interrupt_i !== rx_tvalid_i) begin
                $display("Mismatch at time %0t: test %0d interrupt expected %b got %b",
                         $time, cur_test, rx_tvalid_i, interrupt_i);
                test_errors++;
                error_count++;
            end
            if (chk_sig_i != 8'hff) begin
                got = observed(chk_sig_i);
                test_checks++;
                total_checks++;
                if (chk_sig_i > 8'h10) begin
                    $display("test %0d names unknown signal id %h", cur_test, chk_sig_i);
                    test_errors++;
                    error_count++;
                end else if (got !== chk_exp_i) begin
                    $display("Mismatch at time %0t: test %0d signal %h expected %h got %h",
                             $time, cur_test, chk_sig_i, chk_exp_i, got);
                    test_errors++;
                    error_count++;
                end
            end
        end
    end

endmodule

// ==== verification/tb_hsk_io.sv ====
`include "hsk_io_defines.svh"

module tb_hsk_io;

    logic                    wb_clk_i = 1'b0;
    logic                    sys_rst_i;
    logic                    wb_cyc, wb_stb, wb_we;
    logic [3:0]              wb_sel;
    logic [`HSK_WB_DW-1:0]   wb_dat_w, wb_dat_r;
    logic                    wb_ack, processor_reset;
    logic [7:0]              port_id, out_port, in_port;
    logic                    write_strobe, k_write_strobe, read_strobe, bank, interrupt;
    logic                    cb_en_in, cb_en_out, hsk_en_in, hsk_en_out, hsk_en_t;
    logic [1:0]              conf;
    logic                    sda_in, scl_in, sda_t, scl_t;
    logic [7:0]              bram_data;
    logic                    hsk_reset, bram_we, bram_en;
    logic [`HSK_BRAM_AW-1:0] bram_addr;
    logic [7:0]              rx_tdata, tx_tdata;
    logic                    rx_tvalid, rx_tlast, rx_tuser, rx_tready;
    logic                    tx_tvalid, tx_tlast;
    // check request toward the checker
    logic                    chk_valid = 1'b0;
    int                      chk_test = 0;
    logic [7:0]              chk_sig = 8'hff;
    logic [31:0]             chk_exp = '0;
    logic                    done = 1'b0;
    int                      error_count;
    logic                    summary_done;
    bit                      loaded = 0;
    int                      test_count = 0;
    // parsed vector columns
    int                      v_test[$];
    logic [31:0]             v_op[$], v_port[$], v_data[$], v_flag[$], v_sig[$], v_exp[$];

    always #4 wb_clk_i = ~wb_clk_i;

    hsk_io_top uut (
        .wb_clk_i(wb_clk_i), .sys_rst_i(sys_rst_i), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
        .wb_we_i(wb_we), .wb_sel_i(wb_sel), .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r),
        .wb_ack_o(wb_ack), .processor_reset_o(processor_reset), .port_id_i(port_id),
        .out_port_i(out_port), .write_strobe_i(write_strobe),
        .k_write_strobe_i(k_write_strobe), .read_strobe_i(read_strobe), .bank_i(bank),
        .in_port_o(in_port), .interrupt_o(interrupt), .cratebridge_en_i(cb_en_in),
        .cratebridge_en_o(cb_en_out), .hsk_enable_i(hsk_en_in), .hsk_enable_o(hsk_en_out),
        .hsk_enable_t_o(hsk_en_t), .conf_i(conf), .sda_i(sda_in), .scl_i(scl_in),
        .sda_t_o(sda_t), .scl_t_o(scl_t), .bram_data_i(bram_data), .hsk_reset_o(hsk_reset),
        .bram_addr_o(bram_addr), .bram_we_o(bram_we), .bram_en_o(bram_en),
        .cobs_rx_tdata_i(rx_tdata), .cobs_rx_tvalid_i(rx_tvalid), .cobs_rx_tlast_i(rx_tlast),
        .cobs_rx_tuser_i(rx_tuser), .cobs_rx_tready_o(rx_tready), .cobs_tx_tdata_o(tx_tdata),
        .cobs_tx_tvalid_o(tx_tvalid), .cobs_tx_tlast_o(tx_tlast)
    );

    hsk_io_checker u_checker (
        .clk_i(wb_clk_i), .done_i(done), .chk_valid_i(chk_valid), .chk_test_i(chk_test),
        .chk_sig_i(chk_sig), .chk_exp_i(chk_exp), .rx_tvalid_i(rx_tvalid),
        .processor_reset_i(processor_reset), .cratebridge_en_i(cb_en_out),
        .wb_ack_i(wb_ack), .wb_dat_i(wb_dat_r), .in_port_i(in_port),
        .interrupt_i(interrupt), .scl_t_i(scl_t), .sda_t_i(sda_t), .hsk_enable_t_i(hsk_en_t),
        .hsk_enable_i(hsk_en_out), .hsk_reset_i(hsk_reset), .bram_addr_i(bram_addr),
        .bram_we_i(bram_we), .bram_en_i(bram_en), .cobs_rx_tready_i(rx_tready),
        .cobs_tx_tvalid_i(tx_tvalid), .cobs_tx_tlast_i(tx_tlast), .cobs_tx_tdata_i(tx_tdata),
        .error_count_o(error_count), .summary_done_o(summary_done)
    );

    ////////////////////////////////////////
    // vector file
    ////////////////////////////////////////
    task automatic load_vectors();
        int          fd;
        int          n;
        int          t;
        string       line;
        logic [31:0] op, port, data, flag, sig, exp;
        fd = $fopen("verification/hsk_io_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/hsk_io_tests.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                // comment and blank lines give fewer than seven fields
                n = $sscanf(line, "%d %h %h %h %h %h %h", t, op, port, data, flag, sig, exp);
                if (n == 7) begin
                    if (v_test.size() == 0 || v_test[v_test.size()-1] != t) begin
                        test_count++;
                    end
                    v_test.push_back(t);
                    v_op.push_back(op);
                    v_port.push_back(port);
                    v_data.push_back(data);
                    v_flag.push_back(flag);
                    v_sig.push_back(sig);
                    v_exp.push_back(exp);
                end
            end
            $fclose(fd);
        end
    endtask

    // strobes last one cycle while pins and wishbone hold until changed
    task automatic apply_vector(input int i);
        write_strobe   <= 1'b0;
        k_write_strobe <= 1'b0;
        read_strobe    <= 1'b0;
        case (v_op[i])
            1: begin
                write_strobe <= 1'b1;
                port_id      <= v_port[i][7:0];
                out_port     <= v_data[i][7:0];
            end
            2: begin
                k_write_strobe <= 1'b1;
                port_id        <= v_port[i][7:0];
                out_port       <= v_data[i][7:0];
            end
            3: begin
                read_strobe <= 1'b1;
                port_id     <= v_port[i][7:0];
            end
            4: begin
                wb_cyc   <= 1'b1;
                wb_stb   <= 1'b1;
                wb_we    <= v_flag[i][0];
                wb_dat_w <= v_data[i];
            end
            5: begin
                wb_cyc <= 1'b0;
                wb_stb <= 1'b0;
                wb_we  <= 1'b0;
            end
            6: begin
                rx_tdata <= v_port[i][7:0];
                {rx_tlast, rx_tvalid, hsk_en_in, cb_en_in, conf, scl_in, sda_in} <= v_data[i][7:0];
                bank     <= v_flag[i][1];
                rx_tuser <= v_flag[i][0];
            end
            7: sys_rst_i <= v_data[i][0];
            default: ;
        endcase
        chk_valid <= 1'b1;
        chk_test  <= v_test[i];
        chk_sig   <= v_sig[i][7:0];
        chk_exp   <= v_exp[i];
    endtask

    task automatic idle_cycle();
        @(posedge wb_clk_i);
        write_strobe   <= 1'b0;
        k_write_strobe <= 1'b0;
        read_strobe    <= 1'b0;
        chk_valid      <= 1'b0;
    endtask

    initial begin
        int gap;
        void'($urandom(32'hb82b));
        sys_rst_i = 1'b1;
        {wb_cyc, wb_stb, wb_we, wb_dat_w} = '0;
        wb_sel = 4'b0001;
        {port_id, out_port, write_strobe, k_write_strobe, read_strobe, bank} = '0;
        {cb_en_in, hsk_en_in, conf, sda_in, scl_in} = '0;
        bram_data = 8'ha5;
        {rx_tdata, rx_tvalid, rx_tlast, rx_tuser} = '0;
        load_vectors();
        loaded = 1;
        repeat (2) @(posedge wb_clk_i);
        sys_rst_i <= 1'b0;
        repeat (4) idle_cycle();
        for (int i = 0; i < v_test.size(); i++) begin
            // random idle gap only between tests
            if (i > 0 && v_test[i] != v_test[i-1]) begin
                gap = $urandom % 3;
                repeat (gap) idle_cycle();
            end
            @(posedge wb_clk_i);
            apply_vector(i);
        end
        idle_cycle();
        done <= 1'b1;
        wait (summary_done == 1'b1);
        if (error_count == 0 && test_count > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog budget scales with the number of tests
    initial begin
        wait (loaded);
        repeat (50 * (test_count + 1)) @(posedge wb_clk_i);
        $display("watchdog expired before the tests completed");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== hsk_io.f ====
+incdir+logic
logic/hsk_io_pkg.sv
logic/pb_port_if.sv
logic/port_decode.sv
logic/hsk_control.sv
logic/buffer_ctl.sv
logic/port_readback.sv
logic/hsk_io_top.sv
verification/hsk_io_checker.sv
verification/tb_hsk_io.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the hsk_io testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f hsk_io.f \
    --top-module tb_hsk_io \
    -Mdir obj_dir

./obj_dir/Vtb_hsk_io | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// ==== verification/hsk_io_tests.txt ====
# test op port data flag sig exp, all hex except test
# op 0 idle 1 write 2 kwrite 3 read 4 wb beat 5 wb end 6 pins 7 sys_rst, sig ff skips check
1 6 00 10 0 ff 0
1 4 00 01 1 02 0
1 4 00 01 1 02 1
1 5 00 00 0 00 1
1 4 00 00 0 03 03
1 5 00 00 0 ff 0
1 4 00 00 1 02 0
1 4 00 00 1 00 1
1 5 00 00 0 00 0
1 0 00 00 0 03 02
2 1 11 40 0 07 0
2 0 00 00 0 01 1
2 7 00 01 0 00 0
2 7 00 01 0 00 0
2 7 00 01 0 00 1
2 7 00 00 0 01 0
2 0 00 00 0 00 0
3 1 11 c1 0 07 0
3 1 11 c1 0 08 1
3 0 00 00 0 01 1
3 6 00 38 0 ff 0
3 3 10 00 0 04 50
3 3 11 00 0 04 c1
3 6 00 08 0 ff 0
3 0 00 00 0 ff 0
3 3 11 00 0 04 01
4 1 0d 00 0 05 1
4 0 00 00 0 05 0
4 1 0e 00 0 ff 0
4 0 00 00 0 06 0
4 2 0d 02 0 ff 0
4 0 00 00 0 05 1
4 2 0e 01 0 ff 0
4 0 00 00 0 06 1
4 1 0d 00 0 ff 0
4 1 0e 00 0 05 0
4 0 00 00 0 06 0
4 4 00 01 1 ff 0
4 4 00 01 1 ff 0
4 5 00 00 0 00 1
4 0 00 00 0 05 1
4 0 00 00 0 06 1
4 4 00 00 1 ff 0
4 4 00 00 1 ff 0
4 5 00 00 0 ff 0
4 0 00 00 0 00 0
5 1 0b 02 0 ff 0
5 0 00 00 0 09 0
5 1 85 00 0 0a 745
5 1 85 00 0 0b 1
5 3 85 00 0 04 a5
5 6 00 08 2 ff 0
5 1 0b 80 0 ff 0
5 0 00 00 0 09 1
5 1 85 00 0 0a 705
5 1 0b 02 0 ff 0
5 2 05 00 0 0a 745
5 1 c3 00 0 0a 7c3
5 3 c3 00 0 0a 783
5 3 c3 00 0 0c 1
5 1 11 00 0 ff 0
5 1 c3 00 0 0a 783
5 3 c3 00 0 0a 7c3
6 6 3c c8 1 ff 0
6 3 08 00 0 0d 1
6 3 08 00 0 04 3c
6 3 09 00 0 04 03
6 6 3c 48 0 ff 0
6 3 0a 00 0 04 3c
6 3 0b 00 0 04 00
6 1 08 5e 0 0e 1
6 1 08 5e 0 0f 0
6 1 08 5e 0 10 5e
6 1 09 a7 0 0f 1
6 0 00 00 0 0e 0
6 6 3c 4b 0 ff 0
6 3 0c 00 0 04 03
